/* src/grom_consts.svh */
`ifndef GROM_CONSTS_SVH
`define GROM_CONSTS_SVH

// bank geometry
`define GROM_BANKS 4     // banks actually built
`define GROM_DEPTH 6144  // bytes per bank

// address split, id on top of offset
`define GROM_ID_W  3
`define GROM_OFS_W 13

`endif

/* src/grom_pkg.sv */
`include "grom_consts.svh"

package grom_pkg;

   // bank number, eight decoded
   typedef logic [`GROM_ID_W-1:0] grom_id_t;

   // byte offset inside one bank
   typedef logic [`GROM_OFS_W-1:0] grom_ofs_t;

   typedef logic [7:0] grom_byte_t;

   // full 16 bit GROM address as seen by the CPU
   typedef struct packed {
      grom_id_t  id;   // bits 15:13
      grom_ofs_t ofs;  // bits 12:0
   } grom_addr_t;

endpackage

/* src/grom_loader.sv */
`timescale 1ns/10ps
`include "grom_consts.svh"

module grom_loader (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 load_req_i,
   input  grom_pkg::grom_addr_t load_addr_i,
   input  grom_pkg::grom_byte_t load_data_i,
   output logic                 load_ack_o,
   output logic                 wr_en_o,
   output grom_pkg::grom_id_t   wr_id_o,
   output grom_pkg::grom_ofs_t  wr_ofs_o,
   output grom_pkg::grom_byte_t wr_data_o
);
   import grom_pkg::*;

   typedef enum logic {
      s_idle,  // waiting for req
      s_ack    // ack high, waiting for req to drop
   } state_t;

   state_t     state_q;
   logic       wr_en_q;
   grom_id_t   wr_id_q;
   grom_ofs_t  wr_ofs_q;
   grom_byte_t wr_data_q;
   logic       in_range;
   logic       accept;

   // only banks 0..3 exist, and only the first 6144 bytes of each
   assign in_range = (load_addr_i.id < `GROM_BANKS) && (load_addr_i.ofs < `GROM_DEPTH);
   assign accept   = (state_q == s_idle) && load_req_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= s_idle;
         wr_en_q <= 1'b0;
      end else begin
         wr_en_q <= 1'b0;  // one pulse per request
         case (state_q)
            s_idle: begin
               if (load_req_i) begin
                  state_q <= s_ack;
                  wr_en_q <= in_range;  // out of range still acks
               end
            end
            s_ack: begin
               if (!load_req_i) begin
                  state_q <= s_idle;
               end
            end
            default: state_q <= s_idle;
         endcase
      end
   end

   // request payload, taken with the ack edge
   always_ff @(posedge clk) begin
      if (accept) begin
         wr_id_q   <= load_addr_i.id;
         wr_ofs_q  <= load_addr_i.ofs;
         wr_data_q <= load_data_i;
      end
   end

   assign load_ack_o = (state_q == s_ack);
   assign wr_en_o    = wr_en_q;
   assign wr_id_o    = wr_id_q;
   assign wr_ofs_o   = wr_ofs_q;
   assign wr_data_o  = wr_data_q;

endmodule

/* src/grom_store.sv */
`timescale 1ns/10ps
`include "grom_consts.svh"

module grom_store (
   input  logic                 clk,
   input  logic                 wr_en_i,
   input  grom_pkg::grom_id_t   wr_id_i,
   input  grom_pkg::grom_ofs_t  wr_ofs_i,
   input  grom_pkg::grom_byte_t wr_data_i,
   input  logic                 rd_en_i,
   input  grom_pkg::grom_id_t   rd_id_i,
   input  grom_pkg::grom_ofs_t  rd_ofs_i,
   output grom_pkg::grom_byte_t rd_data_o
);
   import grom_pkg::*;

   localparam int BANK_W = $clog2(`GROM_BANKS);

   grom_byte_t        bank_rd [`GROM_BANKS];  // read register of each bank
   logic [BANK_W-1:0] sel_q;                  // bank of the last read
   logic              hit_q;                  // last read hit a built bank
   logic              rd_hit;

   // ids 4..7 have no storage behind them
   assign rd_hit = (rd_id_i < `GROM_BANKS) && (rd_ofs_i < `GROM_DEPTH);

   for (genvar b = 0; b < `GROM_BANKS; b++) begin : g_bank
      grom_byte_t mem [`GROM_DEPTH];
      grom_byte_t rd_q;

      // writes arrive already range checked
      always_ff @(posedge clk) begin
         if (wr_en_i && (wr_id_i == b)) begin
            mem[wr_ofs_i] <= wr_data_i;
         end
      end

      always_ff @(posedge clk) begin
         if (rd_en_i && rd_hit && (rd_id_i == b)) begin
            rd_q <= mem[rd_ofs_i];
         end
      end

      assign bank_rd[b] = rd_q;
   end

   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         sel_q <= rd_id_i[BANK_W-1:0];
         hit_q <= rd_hit;
      end
   end

   // a missing bank floats high on the real bus
   assign rd_data_o = hit_q ? bank_rd[sel_q] : 8'hff;

endmodule

/* src/grom_port.sv */
`timescale 1ns/10ps
`include "grom_consts.svh"

module grom_port (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 gs_i,
   input  logic                 m_i,
   input  logic                 mo_i,
   input  grom_pkg::grom_byte_t d_i,
   output grom_pkg::grom_byte_t q_o,
   output logic                 rd_en_o,
   output grom_pkg::grom_id_t   rd_id_o,
   output grom_pkg::grom_ofs_t  rd_ofs_o,
   input  grom_pkg::grom_byte_t rd_data_i,
   output grom_pkg::grom_addr_t debug_addr_o
);
   import grom_pkg::*;

   grom_id_t   id_q;       // bank of the current address
   grom_ofs_t  ofs_q;      // offset of the current address
   logic       phase_q;    // first byte of an address pair written
   grom_byte_t q_q;
   grom_byte_t pf_byte_q;  // byte waiting for the next data read
   logic       pf_cap_q;   // store data valid this cycle
   logic       rd_en_q;
   grom_id_t   rd_id_q;
   grom_ofs_t  rd_ofs_q;

   grom_addr_t cur_addr;
   grom_addr_t shift_addr;
   logic       data_rd;
   logic       addr_rd;
   logic       addr_wr;
   logic       wr_fetch;

   assign cur_addr   = {id_q, ofs_q};
   assign shift_addr = {cur_addr[7:0], d_i};  // old low byte moves up

   // access decode, data writes fall through untouched
   assign data_rd  = gs_i && m_i && !mo_i;
   assign addr_rd  = gs_i && m_i && mo_i;
   assign addr_wr  = gs_i && !m_i && mo_i;
   assign wr_fetch = addr_wr && phase_q;  // second byte completes the address

   always_ff @(posedge clk) begin
      if (rst_i) begin
         id_q      <= '0;
         ofs_q     <= '0;
         phase_q   <= 1'b0;
         q_q       <= '0;
         pf_byte_q <= 8'hff;
         pf_cap_q  <= 1'b0;
         rd_en_q   <= 1'b0;
      end else begin
         rd_en_q  <= 1'b0;
         pf_cap_q <= rd_en_q;  // store answers one clock after rd_en
         if (pf_cap_q) begin
            pf_byte_q <= rd_data_i;
         end

         if (data_rd) begin
            q_q     <= pf_byte_q;
            ofs_q   <= ofs_q + 1'b1;  // wraps in 13 bits, id kept
            phase_q <= 1'b0;
            rd_en_q <= 1'b1;
         end

         if (addr_rd) begin
            q_q     <= cur_addr[15:8];
            {id_q, ofs_q[`GROM_OFS_W-1:8]} <= cur_addr[7:0];
            phase_q <= 1'b0;
         end

         if (addr_wr) begin
            id_q    <= shift_addr.id;
            phase_q <= !phase_q;
            if (phase_q) begin
               ofs_q   <= shift_addr.ofs + 1'b1;  // fetched byte sits at the old value
               rd_en_q <= 1'b1;
            end else begin
               ofs_q <= shift_addr.ofs;
            end
         end
      end
   end

   // fetch target, always the address before the increment
   always_ff @(posedge clk) begin
      if (data_rd) begin
         rd_id_q  <= id_q;
         rd_ofs_q <= ofs_q;
      end else if (wr_fetch) begin
         rd_id_q  <= shift_addr.id;
         rd_ofs_q <= shift_addr.ofs;
      end
   end

   assign q_o          = q_q;
   assign rd_en_o      = rd_en_q;
   assign rd_id_o      = rd_id_q;
   assign rd_ofs_o     = rd_ofs_q;
   assign debug_addr_o = cur_addr;

endmodule

/* src/grom_subsystem.sv */
`timescale 1ns/10ps

module grom_subsystem (
   input  logic                 clk,
   input  logic                 rst_i,

   // loader port, four-phase req/ack
   input  logic                 load_req_i,
   input  grom_pkg::grom_addr_t load_addr_i,
   input  grom_pkg::grom_byte_t load_data_i,
   output logic                 load_ack_o,

   // CPU port
   input  logic                 gs_i,
   input  logic                 m_i,
   input  logic                 mo_i,
   input  grom_pkg::grom_byte_t d_i,
   output grom_pkg::grom_byte_t q_o,

   output grom_pkg::grom_addr_t debug_addr_o
);
   import grom_pkg::*;

   logic       wr_en;
   grom_id_t   wr_id;
   grom_ofs_t  wr_ofs;
   grom_byte_t wr_data;
   logic       rd_en;
   grom_id_t   rd_id;
   grom_ofs_t  rd_ofs;
   grom_byte_t rd_data;

   grom_loader u_loader (
      .clk         (clk),
      .rst_i       (rst_i),
      .load_req_i  (load_req_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i),
      .load_ack_o  (load_ack_o),
      .wr_en_o     (wr_en),
      .wr_id_o     (wr_id),
      .wr_ofs_o    (wr_ofs),
      .wr_data_o   (wr_data)
   );

   grom_store u_store (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_id_i   (wr_id),
      .wr_ofs_i  (wr_ofs),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_id_i   (rd_id),
      .rd_ofs_i  (rd_ofs),
      .rd_data_o (rd_data)
   );

   grom_port u_port (
      .clk          (clk),
      .rst_i        (rst_i),
      .gs_i         (gs_i),
      .m_i          (m_i),
      .mo_i         (mo_i),
      .d_i          (d_i),
      .q_o          (q_o),
      .rd_en_o      (rd_en),
      .rd_id_o      (rd_id),
      .rd_ofs_o     (rd_ofs),
      .rd_data_i    (rd_data),
      .debug_addr_o (debug_addr_o)
   );

endmodule

/* testbench/grom_tb.sv */
`timescale 1ns/10ps
`include "grom_consts.svh"

module grom_tb;

   localparam int TIMEOUT = 20;  // cycles allowed per handshake wait

   logic        clk;
   logic        rst_i;
   logic        load_req_i;
   logic [15:0] load_addr_i;
   logic [7:0]  load_data_i;
   logic        load_ack_o;
   logic        gs_i;
   logic        m_i;
   logic        mo_i;
   logic [7:0]  d_i;
   logic [7:0]  q_o;
   logic [15:0] debug_addr_o;

   logic [7:0]  model [0:7][0:`GROM_DEPTH-1];  // mirror of accepted loads
   logic [12:0] run_start [0:`GROM_BANKS-1];   // random loaded run per bank
   int          seed;
   int          errors;
   int          tests;

   grom_subsystem dut (
      .clk          (clk),
      .rst_i        (rst_i),
      .load_req_i   (load_req_i),
      .load_addr_i  (load_addr_i),
      .load_data_i  (load_data_i),
      .load_ack_o   (load_ack_o),
      .gs_i         (gs_i),
      .m_i          (m_i),
      .mo_i         (mo_i),
      .d_i          (d_i),
      .q_o          (q_o),
      .debug_addr_o (debug_addr_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else begin
         $display("Error: %s is %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
   endtask

   function automatic int rand_below(input int limit);
      return int'($unsigned($random(seed)) % limit);
   endfunction

   function automatic logic [15:0] addr_plus(input logic [15:0] a, input int n);
      logic [12:0] ofs;
      ofs = a[12:0] + 13'(n);  // id never changes
      return {a[15:13], ofs};
   endfunction

   function automatic logic [7:0] expected_byte(input logic [15:0] a);
      if (a[12:0] >= `GROM_DEPTH) begin
         return 8'hff;
      end
      return model[a[15:13]][a[12:0]];
   endfunction

   // four-phase write of one byte through the loader
   task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
      int   n;
      logic ack;
      @(negedge clk);
      check_value("load_ack_o", {15'h0, load_ack_o}, 16'h0000);  // no ack before req
      @(posedge clk);
      load_req_i  <= 1'b1;
      load_addr_i <= addr;
      load_data_i <= data;
      n   = 0;
      ack = 1'b0;
      while (!ack && n < TIMEOUT) begin
         @(negedge clk);
         ack = load_ack_o;
         n++;
      end
      assert (ack) else begin
         $display("load handshake timed out, ack never rose for address %h", addr);
         errors++;
      end
      if (ack && addr[15:13] < `GROM_BANKS && addr[12:0] < `GROM_DEPTH) begin
         model[addr[15:13]][addr[12:0]] = data;
      end
      @(posedge clk);
      load_req_i <= 1'b0;
      if (ack) begin
         @(negedge clk);
         check_value("load_ack_o", {15'h0, load_ack_o}, 16'h0001);  // held until req seen low
         n = 0;
         while (ack && n < TIMEOUT) begin
            @(negedge clk);
            ack = load_ack_o;
            n++;
         end
         assert (!ack) else begin
            $display("load handshake timed out, ack never fell after req dropped");
            errors++;
         end
      end
   endtask

   // one CPU strobe, q sampled mid cycle after the strobe edge
   task automatic cpu_access(input logic m, input logic mo, input logic [7:0] d,
                             output logic [7:0] q);
      @(posedge clk);
      gs_i <= 1'b1;
      m_i  <= m;
      mo_i <= mo;
      d_i  <= d;
      @(posedge clk);
      gs_i <= 1'b0;
      @(negedge clk);
      q = q_o;
      repeat (2) @(posedge clk);  // spacing lets the prefetch settle
   endtask

   task automatic write_addr(input logic [15:0] a);
      logic [7:0] q;
      cpu_access(1'b0, 1'b1, a[15:8], q);
      cpu_access(1'b0, 1'b1, a[7:0], q);
   endtask

   task automatic read_data(output logic [7:0] q);
      cpu_access(1'b1, 1'b0, 8'h00, q);
   endtask

   task automatic read_addr(output logic [7:0] q);
      cpu_access(1'b1, 1'b1, 8'h00, q);
   endtask

   // address write, then count data reads checked against the model
   task automatic read_sequence(input logic [15:0] a, input int count);
      logic [7:0] q;
      write_addr(a);
      check_value("debug_addr_o", debug_addr_o, addr_plus(a, 1));
      for (int i = 0; i < count; i++) begin
         read_data(q);
         check_value("q_o", {8'h00, q}, {8'h00, expected_byte(addr_plus(a, i))});
         check_value("debug_addr_o", debug_addr_o, addr_plus(a, i + 2));
      end
   endtask

   task automatic test_reset();
      int         err0;
      logic [7:0] q;
      err0 = errors;
      @(negedge clk);
      check_value("load_ack_o", {15'h0, load_ack_o}, 16'h0000);
      check_value("debug_addr_o", debug_addr_o, 16'h0000);
      read_data(q);
      check_value("q_o", {8'h00, q}, 16'h00ff);  // prefetch byte starts as ff
      check_value("debug_addr_o", debug_addr_o, 16'h0001);
      report_test("reset state", err0);
   endtask

   task automatic test_load();
      int         err0;
      logic [7:0] data;
      err0 = errors;
      for (int b = 0; b < `GROM_BANKS; b++) begin
         run_start[b] = 13'(16 + rand_below(`GROM_DEPTH - 48));
         for (int i = 0; i < 8; i++) begin
            data = 8'($random(seed));
            load_byte({3'(b), 13'(i)}, data);
         end
         for (int i = 0; i < 16; i++) begin
            data = 8'($random(seed));
            load_byte({3'(b), run_start[b] + 13'(i)}, data);
         end
      end
      report_test("load handshake", err0);
   endtask

   task automatic test_seq_read();
      int          err0;
      int          b;
      logic [15:0] a;
      err0 = errors;
      for (int t = 0; t < 4; t++) begin
         b = rand_below(`GROM_BANKS);
         a = {3'(b), run_start[b] + 13'(rand_below(4))};
         read_sequence(a, 8);
      end
      read_sequence({3'd1, 13'h1ffe}, 4);  // wraps to offset 0 of bank 1
      report_test("sequential read", err0);
   endtask

   task automatic test_readback();
      int          err0;
      int          n;
      logic [15:0] a;
      logic [15:0] e;
      logic [7:0]  q;
      err0 = errors;
      for (int t = 0; t < 4; t++) begin
         if (t % 2 == 0) begin
            cpu_access(1'b0, 1'b1, 8'($random(seed)), q);  // lone byte, pair left open
            if (t == 0) begin
               read_addr(q);
            end else begin
               read_data(q);
            end
         end
         a = 16'($random(seed));
         n = rand_below(6);
         write_addr(a);
         check_value("debug_addr_o", debug_addr_o, addr_plus(a, 1));
         for (int i = 0; i < n; i++) begin
            read_data(q);
         end
         e = addr_plus(a, 1 + n);
         read_addr(q);
         check_value("q_o", {8'h00, q}, {8'h00, e[15:8]});
         read_addr(q);
         check_value("q_o", {8'h00, q}, {8'h00, e[7:0]});
      end
      report_test("address readback", err0);
   endtask

   task automatic test_ignored();
      int          err0;
      logic [15:0] a;
      logic [7:0]  q;
      err0 = errors;
      load_byte({3'd5, 13'h0100}, 8'h3c);
      load_byte({3'd2, 13'h1900}, 8'hc3);  // offset 6400, past the bank
      read_sequence({3'd5, 13'h00ff}, 3);
      read_sequence({3'd2, 13'h18ff}, 3);
      read_sequence({3'd2, run_start[2]}, 2);
      for (int id = 4; id < 8; id++) begin
         read_sequence({3'(id), 13'(rand_below(8192))}, 2);
      end
      a = {3'd3, run_start[3]};
      write_addr(a);
      cpu_access(1'b0, 1'b0, 8'($random(seed)), q);  // data write, read-only device
      check_value("debug_addr_o", debug_addr_o, addr_plus(a, 1));
      read_data(q);
      check_value("q_o", {8'h00, q}, {8'h00, expected_byte(a)});
      read_data(q);
      check_value("q_o", {8'h00, q}, {8'h00, expected_byte(addr_plus(a, 1))});
      report_test("ignored accesses", err0);
   endtask

   initial begin
      seed        = 32'hfdf9_bed8;
      errors      = 0;
      tests       = 0;
      rst_i       = 1'b1;
      load_req_i  = 1'b0;
      load_addr_i = 16'h0000;
      load_data_i = 8'h00;
      gs_i        = 1'b0;
      m_i         = 1'b0;
      mo_i        = 1'b0;
      d_i         = 8'h00;
      for (int b = 0; b < 8; b++) begin
         for (int o = 0; o < `GROM_DEPTH; o++) begin
            model[b][o] = 8'hff;
         end
      end
      repeat (4) @(posedge clk);
      rst_i <= 1'b0;

      test_reset();
      test_load();
      test_seq_read();
      test_readback();
      test_ignored();

      $display("tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+src
src/grom_pkg.sv
src/grom_loader.sv
src/grom_store.sv
src/grom_port.sv
src/grom_subsystem.sv
testbench/grom_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = grom_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
